// File: bench/baser_vectors.txt
// valid pattern_check block[65:0] exp_txd exp_txc inc_data inc_ctrl inc_sh inc_fmt inc_pat
// All values hex; block bits [1:0] hold the sync header, a valid-low line expects held outputs
1 1 2AAAAAAAAAAAAAAAA AAAAAAAAAAAAAAAA 00 1 0 0 0 0
1 1 2AAAAAAAAAAAAA956 AAAAAAAAAAAAAA55 00 1 0 0 0 1
1 0 2AAAAAAAAAAAAA956 AAAAAAAAAAAAAA55 00 1 0 0 0 0
1 1 0048D159E26AF37BE 0123456789ABCDEF 00 1 0 0 0 1
1 0 0048D159E26AF37BE 0123456789ABCDEF 00 1 0 0 0 0
0 1 00000000000000000 0123456789ABCDEF 00 0 0 0 0 0
1 0 00000000000000079 0707070707070707 FF 0 1 0 0 0
1 0 00000000000007879 07070707070707FE FF 0 1 0 0 0
1 0 3F800000000000079 FE07070707070707 FF 0 1 0 0 0
1 1 04488CD115599DDE1 11223344556677FB 01 0 1 0 0 1
1 1 2AAAAAAAAAAAAA9E1 AAAAAAAAAAAAAAFB 01 0 1 0 0 0
1 0 0000000004488CD2D 000000001122339C F1 0 1 0 0 0
1 0 0000000404488CD2D 000000001122339C F1 0 1 0 1 0
1 1 0000000000000021D 07070707070707FD FF 0 1 0 0 0
1 1 0000000000002AA65 070707070707FDAA FE 0 1 0 0 0
1 1 00000000002AAAAA9 0707070707FDAAAA FC 0 1 0 0 0
1 1 000000002A956AAD1 07070707FDAA55AA F8 0 1 0 0 1
1 1 0000002AAAAAAAB31 070707FDAAAAAAAA F0 0 1 0 0 0
1 1 001E2AAAAAAAAAB49 07FEFDAAAAAAAAAA E0 0 1 0 0 0
1 1 002AAAAAAAAAAAB85 07FDAAAAAAAAAAAA C0 0 1 0 0 0
1 1 2AAAAAAAAAAAAABFD FDAAAAAAAAAAAAAA 80 0 1 0 0 0
1 1 0000000000000061D 07070707070707FD FF 0 1 0 1 0
1 0 000000000000000CD FEFEFEFEFEFEFEFE FF 0 1 0 1 0
1 1 2AAAAAAAAAAAAAAA8 FEFEFEFEFEFEFEFE FF 0 0 1 0 0
0 0 2AAAAAAAAAAAAAAAA FEFEFEFEFEFEFEFE FF 0 0 0 0 0
1 0 0000000000000007B FEFEFEFEFEFEFEFE FF 0 0 1 0 0
1 1 2AAAAAAAAAAAAAAAA AAAAAAAAAAAAAAAA 00 1 0 0 0 0

// File: bench/tb_baser_rx_checker.sv
// Testbench for the BASE-R receive checker, run from the project root
// Vectors come from bench/baser_vectors.txt, ten hex fields per block
// Pattern count and invalid-block sum are compared only once the pipeline drains
`timescale 1ns/1ps
`default_nettype none

module tb_baser_rx_checker;
    import pcs_pkg::*;

    localparam int FIELDS  = 10;
    localparam int MAX_VEC = 64;

    logic         clk;
    logic         rst;
    logic         i_valid;
    logic         i_pattern_check;
    coded_block_t i_rx_coded;
    mii_data_t    o_txd;
    mii_ctrl_t    o_txc;
    count_t       o_block_count;
    count_t       o_data_count;
    count_t       o_ctrl_count;
    count_t       o_inv_sh_count;
    count_t       o_inv_format_count;
    count_t       o_inv_pattern_count;
    count_t       o_inv_block_count;

    logic [71:0] vec_mem [0:MAX_VEC*FIELDS-1];
    int          num_vec;
    logic        vectors_ready;
    int          word_errors;
    int          count_errors;
    int          other_errors;
    logic [31:0] lfsr;

    // Model state, built from the vector file only
    mii_data_t   exp_txd;
    mii_ctrl_t   exp_txc;
    count_t      exp_blocks;
    count_t      exp_data;
    count_t      exp_ctrl;
    count_t      exp_sh;
    count_t      exp_fmt;
    count_t      exp_pat;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) i_tb_clock_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    baser_rx_checker i_baser_rx_checker (
        .clk                 (clk),
        .i_rst               (rst),
        .i_valid             (i_valid),
        .i_rx_coded          (i_rx_coded),
        .i_pattern_check     (i_pattern_check),
        .o_txd               (o_txd),
        .o_txc               (o_txc),
        .o_block_count       (o_block_count),
        .o_data_count        (o_data_count),
        .o_ctrl_count        (o_ctrl_count),
        .o_inv_sh_count      (o_inv_sh_count),
        .o_inv_format_count  (o_inv_format_count),
        .o_inv_pattern_count (o_inv_pattern_count),
        .o_inv_block_count   (o_inv_block_count)
    );

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    // Idle cycles after a block, 0 to 3, one LFSR step per bit
    task automatic draw_gap(output int gap);
        gap = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr = lfsr_next(lfsr);
            gap  = (gap << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic check_word(input string where_txt);
        assert (o_txd == exp_txd) else begin
            word_errors++;
            $display("ERROR: o_txd = %h, expected %h (%s)", o_txd, exp_txd, where_txt);
        end
        assert (o_txc == exp_txc) else begin
            word_errors++;
            $display("ERROR: o_txc = %h, expected %h (%s)", o_txc, exp_txc, where_txt);
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        assert (got == exp) else begin
            count_errors++;
            $display("ERROR: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_counters();
        check_count("o_block_count", o_block_count, exp_blocks);
        check_count("o_data_count", o_data_count, exp_data);
        check_count("o_ctrl_count", o_ctrl_count, exp_ctrl);
        check_count("o_inv_sh_count", o_inv_sh_count, exp_sh);
        check_count("o_inv_format_count", o_inv_format_count, exp_fmt);
        check_count("o_inv_pattern_count", o_inv_pattern_count, exp_pat);
        check_count("o_inv_block_count", o_inv_block_count, exp_sh + exp_fmt + exp_pat);
    endtask

    initial begin
        int gap;
        int base;
        i_valid         <= 1'b0;
        i_pattern_check <= 1'b0;
        i_rx_coded      <= '0;
        word_errors   = 0;
        count_errors  = 0;
        other_errors  = 0;
        lfsr          = 32'h7e87;
        exp_txd       = '0;
        exp_txc       = '0;
        exp_blocks    = '0;
        exp_data      = '0;
        exp_ctrl      = '0;
        exp_sh        = '0;
        exp_fmt       = '0;
        exp_pat       = '0;
        vectors_ready = 1'b0;

        // Unused slots keep a valid field above 1, which ends the list
        for (int a = 0; a < MAX_VEC * FIELDS; a++) begin
            vec_mem[a] = {8'hEE, 64'(a)};
        end
        $readmemh("bench/baser_vectors.txt", vec_mem);
        num_vec = 0;
        while (num_vec < MAX_VEC && vec_mem[num_vec * FIELDS] <= 72'h1) begin
            num_vec++;
        end
        vectors_ready = 1'b1;
        if (num_vec == 0) begin
            other_errors++;
            $display("No vectors could be read from bench/baser_vectors.txt");
        end

        wait (rst == 1'b1);
        wait (rst == 1'b0);
        @(negedge clk);
        check_word("after reset");
        check_counters();

        for (int n = 0; n < num_vec; n++) begin
            base = n * FIELDS;
            @(posedge clk);
            i_valid         <= vec_mem[base][0];
            i_pattern_check <= vec_mem[base + 1][0];
            i_rx_coded      <= vec_mem[base + 2][65:0];
            @(negedge clk);
            // Outputs still show the block before this one
            check_word($sformatf("before vector %0d", n));
            exp_txd = vec_mem[base + 3][63:0];
            exp_txc = vec_mem[base + 4][7:0];
            if (vec_mem[base][0]) begin
                exp_blocks++;
            end
            exp_data = exp_data + vec_mem[base + 5][31:0];
            exp_ctrl = exp_ctrl + vec_mem[base + 6][31:0];
            exp_sh   = exp_sh + vec_mem[base + 7][31:0];
            exp_fmt  = exp_fmt + vec_mem[base + 8][31:0];
            exp_pat  = exp_pat + vec_mem[base + 9][31:0];

            draw_gap(gap);
            for (int g = 0; g < gap; g++) begin
                @(posedge clk);
                i_valid <= 1'b0;
                @(negedge clk);
                check_word($sformatf("idle cycle %0d after vector %0d", g, n));
            end
            // Two idle cycles let the second counter stage settle
            if (gap >= 2) begin
                check_counters();
            end
        end

        @(posedge clk);
        i_valid <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_word("end of run");
        check_counters();

        $display("Run finished: %0d vectors, %0d word errors, %0d counter errors, %0d other errors",
                 num_vec, word_errors, count_errors, other_errors);
        if (word_errors + count_errors + other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // At most four cycles per vector, plus reset and drain
    initial begin
        wait (vectors_ready);
        repeat (num_vec * 4 + 50) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not complete",
                 num_vec * 4 + 50);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
// Free-running clock and active-high reset asserted from time zero
// Reset drops on a falling edge after RESET_CYCLES rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
common/pcs_pkg.sv
common/block_if.sv
design/block_classifier.sv
design/mii_mapper.sv
design/block_stats.sv
design/baser_rx_checker.sv
bench/tb_clock_gen.sv
bench/tb_baser_rx_checker.sv

// File: common/block_if.sv
// Classified block from the classifier to the mapper and statistics
// No handshake, valid is a one-cycle strobe per block
`timescale 1ns/1ps
`default_nettype none

interface block_if;
    import pcs_pkg::*;

    logic        valid;
    block_kind_e kind;
    lane_idx_t   term_lane;
    // Data block payload, or the 56 bits after the type byte
    mii_data_t   payload;
    logic        format_err;
    logic        sh_err;

    modport classifier (output valid, kind, term_lane, payload, format_err, sh_err);
    modport mapper     (input valid, kind, term_lane, payload);
    modport stats      (input valid, kind, format_err, sh_err);

endinterface

`default_nettype wire

// File: common/pcs_macros.svh
// Widths, code points and character values for the BASE-R receive checker
// Block type codes follow the 64B/66B control block formats
// Sync header sits in the two low bits of the coded block
`ifndef PCS_MACROS_SVH
`define PCS_MACROS_SVH

`define PCS_DATA_W        64
`define PCS_HDR_W         2
`define PCS_LANES         8
`define PCS_CNT_W         32

`define PCS_SH_DATA       2'b10
`define PCS_SH_CTRL       2'b01

// Control block type field
`define PCS_BT_CTRL       8'h1E
`define PCS_BT_START      8'h78
`define PCS_BT_OSET       8'h4B
`define PCS_BT_T0         8'h87
`define PCS_BT_T1         8'h99
`define PCS_BT_T2         8'hAA
`define PCS_BT_T3         8'hB4
`define PCS_BT_T4         8'hCC
`define PCS_BT_T5         8'hD2
`define PCS_BT_T6         8'hE1
`define PCS_BT_T7         8'hFF

`define PCS_CTRL_IDLE     7'h00

// MII characters
`define PCS_MII_IDLE      8'h07
`define PCS_MII_ERROR     8'hFE
`define PCS_MII_START     8'hFB
`define PCS_MII_TERM      8'hFD
`define PCS_MII_SEQ       8'h9C

`define PCS_DATA_PATTERN  8'hAA

`endif

// File: common/pcs_pkg.sv
// Shared types for the BASE-R receive checker
// Widths come from the macro header
`default_nettype none

`include "pcs_macros.svh"

package pcs_pkg;

    // Raw 66-bit block, sync header in bits [1:0]
    typedef logic [`PCS_DATA_W+`PCS_HDR_W-1:0] coded_block_t;

    // MII word, lane 0 in the low byte
    typedef logic [`PCS_DATA_W-1:0] mii_data_t;

    // One bit per lane, set for a control character
    typedef logic [`PCS_LANES-1:0] mii_ctrl_t;

    typedef logic [`PCS_CNT_W-1:0] count_t;

    typedef logic [2:0] lane_idx_t;

    // Block kind as seen by the mapper and the statistics
    typedef enum logic [2:0] {
        KIND_DATA  = 3'd0,
        KIND_CTRL  = 3'd1,
        KIND_START = 3'd2,
        KIND_OSET  = 3'd3,
        KIND_TERM  = 3'd4,
        KIND_ERROR = 3'd5
    } block_kind_e;

endpackage

`default_nettype wire

// File: design/baser_rx_checker.sv
// BASE-R 66-bit receive checker and MII converter, top level
// Plain valid strobe, no back-pressure; outputs hold while i_valid is low
// MII word and most counters one cycle after the block, pattern count
// and invalid-block sum two cycles after
`timescale 1ns/1ps
`default_nettype none

module baser_rx_checker (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic                  i_valid,
    input  pcs_pkg::coded_block_t i_rx_coded,
    input  logic                  i_pattern_check,
    output pcs_pkg::mii_data_t    o_txd,
    output pcs_pkg::mii_ctrl_t    o_txc,
    output pcs_pkg::count_t       o_block_count,
    output pcs_pkg::count_t       o_data_count,
    output pcs_pkg::count_t       o_ctrl_count,
    output pcs_pkg::count_t       o_inv_sh_count,
    output pcs_pkg::count_t       o_inv_format_count,
    output pcs_pkg::count_t       o_inv_pattern_count,
    output pcs_pkg::count_t       o_inv_block_count
);

    block_if blk_bus ();

    block_classifier i_block_classifier (
        .i_valid    (i_valid),
        .i_rx_coded (i_rx_coded),
        .blk        (blk_bus)
    );

    mii_mapper i_mii_mapper (
        .clk   (clk),
        .i_rst (i_rst),
        .blk   (blk_bus),
        .o_txd (o_txd),
        .o_txc (o_txc)
    );

    // Pattern check looks at the registered MII word
    block_stats i_block_stats (
        .clk                 (clk),
        .i_rst               (i_rst),
        .blk                 (blk_bus),
        .i_pattern_check     (i_pattern_check),
        .i_txd               (o_txd),
        .i_txc               (o_txc),
        .o_block_count       (o_block_count),
        .o_data_count        (o_data_count),
        .o_ctrl_count        (o_ctrl_count),
        .o_inv_sh_count      (o_inv_sh_count),
        .o_inv_format_count  (o_inv_format_count),
        .o_inv_pattern_count (o_inv_pattern_count),
        .o_inv_block_count   (o_inv_block_count)
    );

endmodule

`default_nettype wire

// File: design/block_classifier.sv
// Combinational decode of sync header and block type
// Unknown types, nonzero ordered-set zero field and nonzero terminate padding
// raise format_err; a bad sync header raises sh_err alone
`timescale 1ns/1ps
`default_nettype none

`include "pcs_macros.svh"

module block_classifier (
    input  logic                 i_valid,
    input  pcs_pkg::coded_block_t i_rx_coded,
    block_if.classifier          blk
);
    import pcs_pkg::*;

    localparam int FRAME_W = `PCS_DATA_W + `PCS_HDR_W;

    logic [`PCS_HDR_W-1:0] sh;
    logic [7:0]            bt;
    block_kind_e           kind_c;
    lane_idx_t             term_c;
    mii_data_t             payload_c;
    logic                  fmt_c;
    logic                  sh_c;

    // Padding of Tt sits right after the t data bytes and is 7-t bits wide
    function automatic logic pad_nonzero(input mii_data_t p, input lane_idx_t t);
        logic bad;
        bad = 1'b0;
        for (int i = 0; i < 7; i++) begin
            for (int b = 0; b < 7 - i; b++) begin
                if (lane_idx_t'(i) == t && p[8*i + b]) begin
                    bad = 1'b1;
                end
            end
        end
        return bad;
    endfunction

    assign sh = i_rx_coded[`PCS_HDR_W-1:0];
    assign bt = i_rx_coded[`PCS_HDR_W +: 8];

    always_comb begin
        kind_c = KIND_ERROR;
        term_c = '0;
        fmt_c  = 1'b0;
        sh_c   = 1'b0;
        if (sh == `PCS_SH_DATA) begin
            payload_c = i_rx_coded[FRAME_W-1:`PCS_HDR_W];
        end else begin
            payload_c = {8'h00, i_rx_coded[FRAME_W-1:`PCS_HDR_W+8]};
        end

        if (sh == `PCS_SH_DATA) begin
            kind_c = KIND_DATA;
        end else if (sh == `PCS_SH_CTRL) begin
            case (bt)
                `PCS_BT_CTRL:  kind_c = KIND_CTRL;
                `PCS_BT_START: kind_c = KIND_START;
                `PCS_BT_OSET: begin
                    kind_c = KIND_OSET;
                    // Bits above the O code must be zero
                    fmt_c  = |payload_c[55:28];
                end
                `PCS_BT_T0: begin kind_c = KIND_TERM; term_c = 3'd0; end
                `PCS_BT_T1: begin kind_c = KIND_TERM; term_c = 3'd1; end
                `PCS_BT_T2: begin kind_c = KIND_TERM; term_c = 3'd2; end
                `PCS_BT_T3: begin kind_c = KIND_TERM; term_c = 3'd3; end
                `PCS_BT_T4: begin kind_c = KIND_TERM; term_c = 3'd4; end
                `PCS_BT_T5: begin kind_c = KIND_TERM; term_c = 3'd5; end
                `PCS_BT_T6: begin kind_c = KIND_TERM; term_c = 3'd6; end
                `PCS_BT_T7: begin kind_c = KIND_TERM; term_c = 3'd7; end
                default:       fmt_c  = 1'b1;
            endcase
            if (kind_c == KIND_TERM) begin
                fmt_c = pad_nonzero(payload_c, term_c);
            end
        end else begin
            // 00 and 11 are not legal headers
            sh_c = 1'b1;
        end
    end

    assign blk.valid      = i_valid;
    assign blk.kind       = kind_c;
    assign blk.term_lane  = term_c;
    assign blk.payload    = payload_c;
    assign blk.format_err = fmt_c;
    assign blk.sh_err     = sh_c;

endmodule

`default_nettype wire

// File: design/block_stats.sv
// Block counters; type and sync counts one cycle after the block
// Pattern check works on the registered MII word, so the pattern count
// and the invalid-block sum land one cycle later
`timescale 1ns/1ps
`default_nettype none

`include "pcs_macros.svh"

module block_stats (
    input  logic               clk,
    input  logic               i_rst,
    block_if.stats             blk,
    input  logic               i_pattern_check,
    input  pcs_pkg::mii_data_t i_txd,
    input  pcs_pkg::mii_ctrl_t i_txc,
    output pcs_pkg::count_t    o_block_count,
    output pcs_pkg::count_t    o_data_count,
    output pcs_pkg::count_t    o_ctrl_count,
    output pcs_pkg::count_t    o_inv_sh_count,
    output pcs_pkg::count_t    o_inv_format_count,
    output pcs_pkg::count_t    o_inv_pattern_count,
    output pcs_pkg::count_t    o_inv_block_count
);
    import pcs_pkg::*;

    logic   valid_d;
    logic   pat_en_d;
    logic   pat_miss;
    logic   pat_hit;
    count_t pattern_next;

    // Any data lane off the fixed byte marks the whole block
    always_comb begin
        pat_miss = 1'b0;
        for (int j = 0; j < `PCS_LANES; j++) begin
            if (!i_txc[j] && i_txd[8*j +: 8] != `PCS_DATA_PATTERN) begin
                pat_miss = 1'b1;
            end
        end
    end

    assign pat_hit      = valid_d && pat_en_d && pat_miss;
    assign pattern_next = o_inv_pattern_count + count_t'(pat_hit);

    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            valid_d  <= 1'b0;
            pat_en_d <= 1'b0;
        end else begin
            valid_d  <= blk.valid;
            pat_en_d <= i_pattern_check;
        end
    end

    // First stage, straight from the classifier
    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            o_block_count      <= '0;
            o_data_count       <= '0;
            o_ctrl_count       <= '0;
            o_inv_sh_count     <= '0;
            o_inv_format_count <= '0;
        end else if (blk.valid) begin
            o_block_count      <= o_block_count + 1'b1;
            o_data_count       <= o_data_count + count_t'(blk.kind == KIND_DATA);
            o_ctrl_count       <= o_ctrl_count + count_t'(blk.kind != KIND_DATA && !blk.sh_err);
            o_inv_sh_count     <= o_inv_sh_count + count_t'(blk.sh_err);
            o_inv_format_count <= o_inv_format_count + count_t'(blk.format_err);
        end
    end

    // Second stage; sync and format counts already include this block here
    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            o_inv_pattern_count <= '0;
            o_inv_block_count   <= '0;
        end else if (valid_d) begin
            o_inv_pattern_count <= pattern_next;
            o_inv_block_count   <= o_inv_sh_count + o_inv_format_count + pattern_next;
        end
    end

    a_total_covers: assert property (@(posedge clk) disable iff (i_rst)
        {1'b0, o_block_count} >= o_data_count + o_ctrl_count)
        else $error("total block count below data plus control count");

endmodule

`default_nettype wire

// File: design/mii_mapper.sv
// Builds the 8-lane MII word from a classified block, one register stage
// Control character 0x00 maps to idle, every other value to error
`timescale 1ns/1ps
`default_nettype none

`include "pcs_macros.svh"

module mii_mapper (
    input  logic               clk,
    input  logic               i_rst,
    block_if.mapper            blk,
    output pcs_pkg::mii_data_t o_txd,
    output pcs_pkg::mii_ctrl_t o_txc
);
    import pcs_pkg::*;

    mii_data_t txd_next;
    mii_ctrl_t txc_next;

    function automatic logic [7:0] ctrl_to_mii(input logic [6:0] c);
        return (c == `PCS_CTRL_IDLE) ? `PCS_MII_IDLE : `PCS_MII_ERROR;
    endfunction

    // Lane j control character lives at payload[7*j +: 7] in control formats
    always_comb begin
        txd_next = '0;
        txc_next = '0;
        case (blk.kind)
            KIND_DATA: begin
                txd_next = blk.payload;
                txc_next = '0;
            end
            KIND_CTRL: begin
                for (int j = 0; j < `PCS_LANES; j++) begin
                    txd_next[8*j +: 8] = ctrl_to_mii(blk.payload[7*j +: 7]);
                end
                txc_next = '1;
            end
            KIND_START: begin
                txd_next = {blk.payload[55:0], `PCS_MII_START};
                txc_next = 8'h01;
            end
            KIND_OSET: begin
                // Sequence, three data lanes, upper half zeroed
                txd_next = {32'h0000_0000, blk.payload[23:0], `PCS_MII_SEQ};
                txc_next = 8'hF1;
            end
            KIND_TERM: begin
                for (int j = 0; j < `PCS_LANES; j++) begin
                    if (lane_idx_t'(j) < blk.term_lane) begin
                        txd_next[8*j +: 8] = blk.payload[8*j +: 8];
                        txc_next[j]        = 1'b0;
                    end else if (lane_idx_t'(j) == blk.term_lane) begin
                        txd_next[8*j +: 8] = `PCS_MII_TERM;
                        txc_next[j]        = 1'b1;
                    end else begin
                        txd_next[8*j +: 8] = ctrl_to_mii(blk.payload[7*j +: 7]);
                        txc_next[j]        = 1'b1;
                    end
                end
            end
            default: begin
                txd_next = {`PCS_LANES{`PCS_MII_ERROR}};
                txc_next = '1;
            end
        endcase
    end

    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            o_txd <= '0;
            o_txc <= '0;
        end else if (blk.valid) begin
            o_txd <= txd_next;
            o_txc <= txc_next;
        end
    end

    a_txc_known: assert property (@(posedge clk) disable iff (i_rst) !$isunknown(o_txc))
        else $error("o_txc carries X or Z out of reset");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compiles and runs the BASE-R checker testbench with Verilator
# Run from anywhere; paths are taken relative to the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_baser_rx_checker --Mdir obj_dir -f build.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_baser_rx_checker > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
